// File: mrdma_cfg_pkg.sv
`default_nettype none

// ====================
// register fields of the cube description
// ====================

package mrdma_cfg_pkg;

  // input precision, register encoding
  typedef enum logic [1:0] {
    prec_int8  = 2'd0,
    prec_int16 = 2'd1,
    prec_fp16  = 2'd2
  } precision_e;

  // channel, height and width fields
  localparam int dim_w = 13;

  // batch number field, value is batches minus one
  localparam int batch_w = 5;

  // last channel-block index
  // int8 packs 32 channels per block, others 16
  localparam int cblk_w = 9;

endpackage

`default_nettype wire

// File: mrdma_dma_pkg.sv
`default_nettype none

// ====================
// dma request and context queue layout
// ====================

package mrdma_dma_pkg;

  // 32-byte atom
  localparam int atom_shift = 5;

  // request size field, sits above the byte address in the request
  localparam int size_w = 15;

  // strides and low base address are given in atoms
  localparam int stride_w = 27;

  // context queue entry
  localparam int cq_pd_w = 14;
  localparam int cq_size_w = cq_pd_w - 1;

  // queue entry layout, cube end flag on top
  typedef struct packed {
    logic                 cube_end;
    logic [cq_size_w-1:0] size;
  } cq_pd_t;

endpackage

`default_nettype wire

// File: cube_step_if.sv
`timescale 1ns/1ps
`default_nettype none

// one step of the cube walk
interface cube_step_if;

  // step taken by both dma and queue
  logic accept;

  // end flags of the current step
  logic line_end;
  logic surf_end;
  logic cube_end;

  // counters, own the end flags
  modport walker (input accept, output line_end, surf_end, cube_end);

  // address registers
  modport addr (input accept, line_end, surf_end);

  // handshake side, makes accept
  modport issue (output accept, input cube_end);

endinterface

`default_nettype wire

// File: mrdma_cfg_decode.sv
`timescale 1ns/1ps
`default_nettype none

module mrdma_cfg_decode (
  input  wire logic [mrdma_cfg_pkg::dim_w-1:0]                 reg2dp_channel,
  input  wire logic [mrdma_cfg_pkg::dim_w-1:0]                 reg2dp_height,
  input  wire logic [mrdma_cfg_pkg::dim_w-1:0]                 reg2dp_width,
  input  wire logic [$bits(mrdma_cfg_pkg::precision_e)-1:0]    reg2dp_in_precision,
  output logic                                                  mode_1x1,
  output logic [mrdma_cfg_pkg::cblk_w-1:0]                      cblk_last,
  output logic [mrdma_dma_pkg::size_w-1:0]                      req_size
);

  localparam int DW = mrdma_cfg_pkg::dim_w;
  localparam int CW = mrdma_cfg_pkg::cblk_w;
  localparam int SW = mrdma_dma_pkg::size_w;

  mrdma_cfg_pkg::precision_e in_prec;

  assign in_prec = mrdma_cfg_pkg::precision_e'(reg2dp_in_precision);

  // ====================
  // channel blocks
  // ====================

  // int8 block is 32 channels, int16 and fp16 are 16
  always_comb begin
    if (in_prec == mrdma_cfg_pkg::prec_int8) begin
      cblk_last = {1'b0, reg2dp_channel[DW-1:DW-CW+1]};
    end else begin
      cblk_last = reg2dp_channel[DW-1:DW-CW];
    end
  end

  // 1x1 pack when the plane is a single element
  assign mode_1x1 = (reg2dp_height == '0) && (reg2dp_width == '0);

  // one request covers the whole channel in 1x1 pack
  // otherwise one line of width atoms
  assign req_size = mode_1x1 ? {{(SW-CW){1'b0}}, cblk_last}
                             : {{(SW-DW){1'b0}}, reg2dp_width};

endmodule

`default_nettype wire

// File: mrdma_cube_walker.sv
`timescale 1ns/1ps
`default_nettype none

module mrdma_cube_walker (
  input  wire logic                               nvdla_core_clk,
  input  wire logic                               nvdla_core_rstn,
  input  wire logic [mrdma_cfg_pkg::batch_w-1:0]  reg2dp_batch_number,
  input  wire logic [mrdma_cfg_pkg::dim_w-1:0]    reg2dp_height,
  input  wire logic                               mode_1x1,
  input  wire logic [mrdma_cfg_pkg::cblk_w-1:0]   cblk_last,
  cube_step_if.walker                             step
);

  localparam int BW = mrdma_cfg_pkg::batch_w;
  localparam int HW = mrdma_cfg_pkg::dim_w;
  localparam int CW = mrdma_cfg_pkg::cblk_w;

  logic [BW-1:0] count_b;
  logic [HW-1:0] count_h;
  logic [CW-1:0] count_c;

  logic is_last_h;
  logic is_last_c;

  // ====================
  // end flags
  // ====================

  // batch is the innermost loop, so a batch end closes a line
  assign step.line_end = (count_b == reg2dp_batch_number);
  assign is_last_h = (count_h == reg2dp_height);
  assign is_last_c = (count_c == cblk_last);

  // 1x1 pack has no lines, every batch end closes the surface
  assign step.surf_end = step.line_end && (mode_1x1 || is_last_h);
  assign step.cube_end = step.surf_end && (mode_1x1 || is_last_c);

  // ====================
  // counters
  // ====================

  // batch
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_b <= '0;
    end else if (step.accept) begin
      if (step.line_end) begin
        count_b <= '0;
      end else begin
        count_b <= count_b + BW'(1);
      end
    end
  end

  // line, wraps at surface end
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_h <= '0;
    end else if (step.accept) begin
      if (step.surf_end) begin
        count_h <= '0;
      end else if (step.line_end) begin
        count_h <= count_h + HW'(1);
      end
    end
  end

  // channel block, wraps at cube end
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_c <= '0;
    end else if (step.accept) begin
      if (step.cube_end) begin
        count_c <= '0;
      end else if (step.surf_end) begin
        count_c <= count_c + CW'(1);
      end
    end
  end

endmodule

`default_nettype wire

// File: mrdma_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module mrdma_addr_gen #(
  parameter int ADDR_W = 64
) (
  input  wire logic                     nvdla_core_clk,
  input  wire logic                     nvdla_core_rstn,
  input  wire logic                     op_load,
  input  wire logic [ADDR_W-mrdma_dma_pkg::atom_shift-mrdma_dma_pkg::stride_w-1:0]
                                        reg2dp_src_base_addr_high,
  input  wire logic [mrdma_dma_pkg::stride_w-1:0] reg2dp_src_base_addr_low,
  input  wire logic [mrdma_dma_pkg::stride_w-1:0] reg2dp_src_line_stride,
  input  wire logic [mrdma_dma_pkg::stride_w-1:0] reg2dp_src_surface_stride,
  cube_step_if.addr                     step,
  output logic [ADDR_W-1:0]             line_addr
);

  // atom address and the part above the strides
  localparam int AW = ADDR_W - mrdma_dma_pkg::atom_shift;
  localparam int HW = AW - mrdma_dma_pkg::stride_w;

  logic [AW-1:0] base_line;
  logic [AW-1:0] base_surf;
  logic [AW-1:0] surf_next;
  logic [AW-1:0] line_next;

  // next bases, strides zero extended
  assign surf_next = base_surf + {{HW{1'b0}}, reg2dp_src_surface_stride};
  assign line_next = base_line + {{HW{1'b0}}, reg2dp_src_line_stride};

  // ====================
  // base registers
  // ====================

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      base_surf <= '0;
      base_line <= '0;
    end else if (op_load) begin
      base_surf <= {reg2dp_src_base_addr_high, reg2dp_src_base_addr_low};
      base_line <= {reg2dp_src_base_addr_high, reg2dp_src_base_addr_low};
    end else if (step.accept) begin
      // new channel block, first line sits on the new surface
      if (step.surf_end) begin
        base_surf <= surf_next;
        base_line <= surf_next;
      end else if (step.line_end) begin
        base_line <= line_next;
      end
    end
  end

  // byte address, always atom aligned
  assign line_addr = {base_line, {mrdma_dma_pkg::atom_shift{1'b0}}};

endmodule

`default_nettype wire

// File: mrdma_req_issue.sv
`timescale 1ns/1ps
`default_nettype none

module mrdma_req_issue #(
  parameter int ADDR_W = 64
) (
  input  wire logic                                     nvdla_core_clk,
  input  wire logic                                     nvdla_core_rstn,
  input  wire logic                                     op_load,
  input  wire logic [ADDR_W-1:0]                        line_addr,
  input  wire logic [mrdma_dma_pkg::size_w-1:0]         req_size,
  input  wire logic                                     dma_rd_req_rdy,
  input  wire logic                                     ig2cq_prdy,
  output logic [ADDR_W+mrdma_dma_pkg::size_w-1:0]       dma_rd_req_pd,
  output logic                                          dma_rd_req_vld,
  output logic [mrdma_dma_pkg::cq_pd_w-1:0]             ig2cq_pd,
  output logic                                          ig2cq_pvld,
  cube_step_if.issue                                    step
);

  logic active;
  mrdma_dma_pkg::cq_pd_t cq_entry;

  // operation in flight, up to the accept of the last step
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      active <= 1'b0;
    end else if (op_load) begin
      active <= 1'b1;
    end else if (step.accept && step.cube_end) begin
      active <= 1'b0;
    end
  end

  // ====================
  // joint handshake
  // ====================

  // each valid waits on the other side's ready
  // so dma and queue always transfer in the same cycle
  assign dma_rd_req_vld = active && ig2cq_prdy;
  assign ig2cq_pvld = active && dma_rd_req_rdy;
  assign step.accept = dma_rd_req_vld && dma_rd_req_rdy;

  // request, size above the address
  assign dma_rd_req_pd = {req_size, line_addr};

  // queue entry for the egress side
  assign cq_entry.cube_end = step.cube_end;
  assign cq_entry.size = req_size[mrdma_dma_pkg::cq_size_w-1:0];
  assign ig2cq_pd = cq_entry;

endmodule

`default_nettype wire

// File: mrdma_stall_counter.sv
`timescale 1ns/1ps
`default_nettype none

module mrdma_stall_counter #(
  parameter int STALL_W = 32
) (
  input  wire logic               nvdla_core_clk,
  input  wire logic               nvdla_core_rstn,
  input  wire logic               op_load,
  input  wire logic               reg2dp_perf_dma_en,
  input  wire logic               dma_rd_req_vld,
  input  wire logic               dma_rd_req_rdy,
  output logic [STALL_W-1:0]      dp2reg_mrdma_stall
);

  logic cnt_en;
  logic [STALL_W-1:0] stall_cnt;

  // enable is sampled once per operation
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cnt_en <= 1'b0;
    end else if (op_load) begin
      cnt_en <= reg2dp_perf_dma_en;
    end
  end

  // counts request cycles held off by the dma side
  // a new operation always starts from zero
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      stall_cnt <= '0;
    end else if (op_load) begin
      stall_cnt <= '0;
    end else if (cnt_en && dma_rd_req_vld && !dma_rd_req_rdy) begin
      stall_cnt <= stall_cnt + STALL_W'(1);
    end
  end

  assign dp2reg_mrdma_stall = stall_cnt;

endmodule

`default_nettype wire

// File: mrdma_ig.sv
`timescale 1ns/1ps
`default_nettype none

module mrdma_ig #(
  parameter int ADDR_W = 64,
  parameter int STALL_W = 32
) (
  input  wire logic nvdla_core_clk,
  input  wire logic nvdla_core_rstn,
  input  wire logic op_load,
  input  wire logic [mrdma_cfg_pkg::batch_w-1:0]               reg2dp_batch_number,
  input  wire logic [mrdma_cfg_pkg::dim_w-1:0]                 reg2dp_channel,
  input  wire logic [mrdma_cfg_pkg::dim_w-1:0]                 reg2dp_height,
  input  wire logic [mrdma_cfg_pkg::dim_w-1:0]                 reg2dp_width,
  input  wire logic [$bits(mrdma_cfg_pkg::precision_e)-1:0]    reg2dp_in_precision,
  input  wire logic [ADDR_W-mrdma_dma_pkg::atom_shift-mrdma_dma_pkg::stride_w-1:0]
                    reg2dp_src_base_addr_high,
  input  wire logic [mrdma_dma_pkg::stride_w-1:0]              reg2dp_src_base_addr_low,
  input  wire logic [mrdma_dma_pkg::stride_w-1:0]              reg2dp_src_line_stride,
  input  wire logic [mrdma_dma_pkg::stride_w-1:0]              reg2dp_src_surface_stride,
  input  wire logic reg2dp_perf_dma_en,
  output logic [ADDR_W+mrdma_dma_pkg::size_w-1:0]              dma_rd_req_pd,
  output logic      dma_rd_req_vld,
  input  wire logic dma_rd_req_rdy,
  output logic [mrdma_dma_pkg::cq_pd_w-1:0]                    ig2cq_pd,
  output logic      ig2cq_pvld,
  input  wire logic ig2cq_prdy,
  output logic [STALL_W-1:0]                                   dp2reg_mrdma_stall
);

  logic                                mode_1x1;
  logic [mrdma_cfg_pkg::cblk_w-1:0]    cblk_last;
  logic [mrdma_dma_pkg::size_w-1:0]    req_size;
  logic [ADDR_W-1:0]                   line_addr;

  // per-step handshake and end flags
  cube_step_if step ();

  // ====================
  // cube walk
  // ====================

  mrdma_cfg_decode u_cfg_decode (
    .reg2dp_channel      (reg2dp_channel),
    .reg2dp_height       (reg2dp_height),
    .reg2dp_width        (reg2dp_width),
    .reg2dp_in_precision (reg2dp_in_precision),
    .mode_1x1            (mode_1x1),
    .cblk_last           (cblk_last),
    .req_size            (req_size)
  );

  mrdma_cube_walker u_cube_walker (
    .nvdla_core_clk      (nvdla_core_clk),
    .nvdla_core_rstn     (nvdla_core_rstn),
    .reg2dp_batch_number (reg2dp_batch_number),
    .reg2dp_height       (reg2dp_height),
    .mode_1x1            (mode_1x1),
    .cblk_last           (cblk_last),
    .step                (step.walker)
  );

  mrdma_addr_gen #(.ADDR_W(ADDR_W)) u_addr_gen (
    .nvdla_core_clk            (nvdla_core_clk),
    .nvdla_core_rstn           (nvdla_core_rstn),
    .op_load                   (op_load),
    .reg2dp_src_base_addr_high (reg2dp_src_base_addr_high),
    .reg2dp_src_base_addr_low  (reg2dp_src_base_addr_low),
    .reg2dp_src_line_stride    (reg2dp_src_line_stride),
    .reg2dp_src_surface_stride (reg2dp_src_surface_stride),
    .step                      (step.addr),
    .line_addr                 (line_addr)
  );

  // ====================
  // request side
  // ====================

  mrdma_req_issue #(.ADDR_W(ADDR_W)) u_req_issue (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .line_addr       (line_addr),
    .req_size        (req_size),
    .dma_rd_req_rdy  (dma_rd_req_rdy),
    .ig2cq_prdy      (ig2cq_prdy),
    .dma_rd_req_pd   (dma_rd_req_pd),
    .dma_rd_req_vld  (dma_rd_req_vld),
    .ig2cq_pd        (ig2cq_pd),
    .ig2cq_pvld      (ig2cq_pvld),
    .step            (step.issue)
  );

  // perf counter, sees the same valid as the dma port
  mrdma_stall_counter #(.STALL_W(STALL_W)) u_stall_counter (
    .nvdla_core_clk     (nvdla_core_clk),
    .nvdla_core_rstn    (nvdla_core_rstn),
    .op_load            (op_load),
    .reg2dp_perf_dma_en (reg2dp_perf_dma_en),
    .dma_rd_req_vld     (dma_rd_req_vld),
    .dma_rd_req_rdy     (dma_rd_req_rdy),
    .dp2reg_mrdma_stall (dp2reg_mrdma_stall)
  );

endmodule

`default_nettype wire

// File: tb_mrdma_ig.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mrdma_ig;

  localparam int ADDR_W = 64;
  localparam int STALL_W = 32;
  localparam int SIZE_W = mrdma_dma_pkg::size_w;
  localparam int PD_W = ADDR_W + SIZE_W;
  localparam int HIGH_W = ADDR_W - mrdma_dma_pkg::atom_shift - mrdma_dma_pkg::stride_w;
  localparam int SW = mrdma_dma_pkg::stride_w;
  localparam int TIMEOUT = 2000;

  logic nvdla_core_clk;
  logic nvdla_core_rstn;
  logic op_load;
  logic [mrdma_cfg_pkg::batch_w-1:0] reg2dp_batch_number;
  logic [mrdma_cfg_pkg::dim_w-1:0] reg2dp_channel;
  logic [mrdma_cfg_pkg::dim_w-1:0] reg2dp_height;
  logic [mrdma_cfg_pkg::dim_w-1:0] reg2dp_width;
  logic [1:0] reg2dp_in_precision;
  logic [HIGH_W-1:0] reg2dp_src_base_addr_high;
  logic [SW-1:0] reg2dp_src_base_addr_low;
  logic [SW-1:0] reg2dp_src_line_stride;
  logic [SW-1:0] reg2dp_src_surface_stride;
  logic reg2dp_perf_dma_en;
  logic [PD_W-1:0] dma_rd_req_pd;
  logic dma_rd_req_vld;
  logic dma_rd_req_rdy;
  logic [mrdma_dma_pkg::cq_pd_w-1:0] ig2cq_pd;
  logic ig2cq_pvld;
  logic ig2cq_prdy;
  logic [STALL_W-1:0] dp2reg_mrdma_stall;

  int err_count;
  int check_count;

  // expected request stream from the walk model
  logic [ADDR_W-1:0] exp_addr[$];
  logic [SIZE_W-1:0] exp_size[$];
  logic exp_end[$];

  mrdma_ig #(.ADDR_W(ADDR_W), .STALL_W(STALL_W)) uut (
    .nvdla_core_clk            (nvdla_core_clk),
    .nvdla_core_rstn           (nvdla_core_rstn),
    .op_load                   (op_load),
    .reg2dp_batch_number       (reg2dp_batch_number),
    .reg2dp_channel            (reg2dp_channel),
    .reg2dp_height             (reg2dp_height),
    .reg2dp_width              (reg2dp_width),
    .reg2dp_in_precision       (reg2dp_in_precision),
    .reg2dp_src_base_addr_high (reg2dp_src_base_addr_high),
    .reg2dp_src_base_addr_low  (reg2dp_src_base_addr_low),
    .reg2dp_src_line_stride    (reg2dp_src_line_stride),
    .reg2dp_src_surface_stride (reg2dp_src_surface_stride),
    .reg2dp_perf_dma_en        (reg2dp_perf_dma_en),
    .dma_rd_req_pd             (dma_rd_req_pd),
    .dma_rd_req_vld            (dma_rd_req_vld),
    .dma_rd_req_rdy            (dma_rd_req_rdy),
    .ig2cq_pd                  (ig2cq_pd),
    .ig2cq_pvld                (ig2cq_pvld),
    .ig2cq_prdy                (ig2cq_prdy),
    .dp2reg_mrdma_stall        (dp2reg_mrdma_stall)
  );

  // 10 ns clock
  initial begin
    nvdla_core_clk = 1'b0;
    forever #5 nvdla_core_clk = ~nvdla_core_clk;
  end

  // ====================
  // checks
  // ====================

  task automatic check_value(input string name, input logic [PD_W-1:0] got,
                             input logic [PD_W-1:0] exp);
    check_count++;
    assert (got === exp) else begin
      err_count++;
      $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic check_cond(input bit ok, input string what);
    check_count++;
    assert (ok) else begin
      err_count++;
      $display("Error at %0t: %s", $time, what);
    end
  endtask

  // ====================
  // stimulus helpers
  // ====================

  task automatic apply_reset();
    nvdla_core_rstn = 1'b0;
    repeat (3) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;
  endtask

  task automatic set_cube(input int batches, input int ch, input int h, input int w,
                          input logic [1:0] prec);
    reg2dp_batch_number = mrdma_cfg_pkg::batch_w'(batches - 1);
    reg2dp_channel = mrdma_cfg_pkg::dim_w'(ch - 1);
    reg2dp_height = mrdma_cfg_pkg::dim_w'(h);
    reg2dp_width = mrdma_cfg_pkg::dim_w'(w);
    reg2dp_in_precision = prec;
  endtask

  // one cycle pulse that returns on the falling edge after the load edge
  task automatic start_op(input logic en);
    @(negedge nvdla_core_clk);
    reg2dp_perf_dma_en = en;
    op_load = 1'b1;
    @(negedge nvdla_core_clk);
    op_load = 1'b0;
  endtask

  // let the rest of the walk go with both readies high
  task automatic drain_op();
    int cycles;
    bit idle;
    cycles = 0;
    idle = 1'b0;
    dma_rd_req_rdy = 1'b1;
    ig2cq_prdy = 1'b1;
    while (!idle && cycles < TIMEOUT) begin
      #1;
      if (!dma_rd_req_vld) begin
        idle = 1'b1;
      end else begin
        @(negedge nvdla_core_clk);
        cycles++;
      end
    end
    check_cond(idle, "timeout, request valid never dropped while draining");
  endtask

  // walk model with the batch loop innermost and the channel-block loop outermost
  task automatic build_expected();
    int n_b;
    int n_h;
    int n_c;
    int cblk;
    int total;
    int idx;
    logic mode;
    logic [ADDR_W-1:0] base_atoms;
    logic [ADDR_W-1:0] ls_ext;
    logic [ADDR_W-1:0] ss_ext;
    logic [ADDR_W-1:0] atom;
    exp_addr.delete();
    exp_size.delete();
    exp_end.delete();
    mode = (reg2dp_height == '0) && (reg2dp_width == '0);
    // int8 blocks hold 32 channels and the others 16
    if (reg2dp_in_precision == mrdma_cfg_pkg::prec_int8) begin
      cblk = int'(reg2dp_channel >> 5);
    end else begin
      cblk = int'(reg2dp_channel >> 4);
    end
    n_b = int'(reg2dp_batch_number) + 1;
    n_h = mode ? 1 : int'(reg2dp_height) + 1;
    n_c = mode ? 1 : cblk + 1;
    total = n_b * n_h * n_c;
    base_atoms = ADDR_W'({reg2dp_src_base_addr_high, reg2dp_src_base_addr_low});
    ls_ext = ADDR_W'(reg2dp_src_line_stride);
    ss_ext = ADDR_W'(reg2dp_src_surface_stride);
    idx = 0;
    for (int c = 0; c < n_c; c++) begin
      for (int h = 0; h < n_h; h++) begin
        for (int b = 0; b < n_b; b++) begin
          atom = base_atoms + ADDR_W'(c) * ss_ext + ADDR_W'(h) * ls_ext;
          exp_addr.push_back(atom << mrdma_dma_pkg::atom_shift);
          exp_size.push_back(mode ? SIZE_W'(cblk) : SIZE_W'(reg2dp_width));
          exp_end.push_back(idx == total - 1);
          idx++;
        end
      end
    end
  endtask

  // run one operation and compare every accepted step with the model
  task automatic run_walk(input bit random_rdy);
    int idx;
    int cycles;
    logic dma_acc;
    logic cq_acc;
    build_expected();
    start_op(1'b0);
    idx = 0;
    cycles = 0;
    while (idx < exp_addr.size() && cycles < TIMEOUT) begin
      if (random_rdy) begin
        dma_rd_req_rdy = 1'($urandom_range(0, 1));
        ig2cq_prdy = 1'($urandom_range(0, 1));
      end else begin
        dma_rd_req_rdy = 1'b1;
        ig2cq_prdy = 1'b1;
      end
      #1;
      dma_acc = dma_rd_req_vld && dma_rd_req_rdy;
      cq_acc = ig2cq_pvld && ig2cq_prdy;
      check_value("dma accept vs ig2cq accept", PD_W'(dma_acc), PD_W'(cq_acc));
      if (dma_acc) begin
        check_value("dma_rd_req_pd.addr", PD_W'(dma_rd_req_pd[ADDR_W-1:0]),
                    PD_W'(exp_addr[idx]));
        check_value("dma_rd_req_pd.size", PD_W'(dma_rd_req_pd[ADDR_W +: SIZE_W]),
                    PD_W'(exp_size[idx]));
        check_value("ig2cq_pd.size", PD_W'(ig2cq_pd[12:0]), PD_W'(exp_size[idx][12:0]));
        check_value("ig2cq_pd.cube_end", PD_W'(ig2cq_pd[13]), PD_W'(exp_end[idx]));
        idx++;
      end
      @(negedge nvdla_core_clk);
      cycles++;
    end
    check_cond(idx == exp_addr.size(), "timeout, not every request of the walk was accepted");
    // active has dropped after the cube end accept
    dma_rd_req_rdy = 1'b1;
    ig2cq_prdy = 1'b1;
    #1;
    check_value("dma_rd_req_vld", PD_W'(dma_rd_req_vld), '0);
    check_value("ig2cq_pvld", PD_W'(ig2cq_pvld), '0);
  endtask

  // ====================
  // directed tests
  // ====================

  task automatic idle_after_reset();
    dma_rd_req_rdy = 1'b1;
    ig2cq_prdy = 1'b1;
    repeat (5) begin
      @(negedge nvdla_core_clk);
      #1;
      check_value("dma_rd_req_vld", PD_W'(dma_rd_req_vld), '0);
      check_value("ig2cq_pvld", PD_W'(ig2cq_pvld), '0);
      check_value("dp2reg_mrdma_stall", PD_W'(dp2reg_mrdma_stall), '0);
    end
  endtask

  task automatic walk_ready_high();
    set_cube(2, 40, 1, 7, mrdma_cfg_pkg::prec_int16);
    run_walk(1'b0);
  endtask

  // one request per batch and all on the base address
  task automatic walk_pack_1x1();
    set_cube(4, 100, 0, 0, mrdma_cfg_pkg::prec_int8);
    run_walk(1'b0);
  endtask

  task automatic walk_random_ready();
    set_cube(2, 40, 1, 7, mrdma_cfg_pkg::prec_int16);
    run_walk(1'b1);
  endtask

  task automatic stall_counting();
    int n;
    n = 7;
    set_cube(2, 40, 1, 7, mrdma_cfg_pkg::prec_int16);
    dma_rd_req_rdy = 1'b0;
    ig2cq_prdy = 1'b1;
    start_op(1'b1);
    repeat (n) @(negedge nvdla_core_clk);
    check_value("dp2reg_mrdma_stall", PD_W'(dp2reg_mrdma_stall), PD_W'(n));
    drain_op();
    check_value("dp2reg_mrdma_stall", PD_W'(dp2reg_mrdma_stall), PD_W'(n));
    // a new load clears the count and counting starts again
    dma_rd_req_rdy = 1'b0;
    start_op(1'b1);
    check_value("dp2reg_mrdma_stall", PD_W'(dp2reg_mrdma_stall), '0);
    repeat (n) @(negedge nvdla_core_clk);
    check_value("dp2reg_mrdma_stall", PD_W'(dp2reg_mrdma_stall), PD_W'(n));
    drain_op();
    // a load with counting off still clears the count
    dma_rd_req_rdy = 1'b0;
    start_op(1'b0);
    check_value("dp2reg_mrdma_stall", PD_W'(dp2reg_mrdma_stall), '0);
    repeat (n) @(negedge nvdla_core_clk);
    check_value("dp2reg_mrdma_stall", PD_W'(dp2reg_mrdma_stall), '0);
    drain_op();
  endtask

  // ====================
  // main sequence
  // ====================

  initial begin
    err_count = 0;
    check_count = 0;
    void'($urandom(32'h8da965c5));
    nvdla_core_rstn = 1'b0;
    op_load = 1'b0;
    set_cube(1, 1, 0, 0, mrdma_cfg_pkg::prec_int8);
    reg2dp_src_base_addr_high = 32'h0000_0012;
    reg2dp_src_base_addr_low = 27'h001_2340;
    reg2dp_src_line_stride = 27'h000_0040;
    reg2dp_src_surface_stride = 27'h000_0800;
    reg2dp_perf_dma_en = 1'b0;
    dma_rd_req_rdy = 1'b0;
    ig2cq_prdy = 1'b0;
    apply_reset();
    idle_after_reset();
    walk_ready_high();
    walk_pack_1x1();
    walk_random_ready();
    stall_counting();
    $display("checks %0d errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
mrdma_cfg_pkg.sv
mrdma_dma_pkg.sv
cube_step_if.sv
mrdma_cfg_decode.sv
mrdma_cube_walker.sv
mrdma_addr_gen.sv
mrdma_req_issue.sv
mrdma_stall_counter.sv
mrdma_ig.sv
tb_mrdma_ig.sv

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= tb_mrdma_ig
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run fails unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
